// ==== hdl/decode_pkg.sv ====
//////////////////////////////
// Decode package
// Word and register index types, instruction field positions
// and the opcode, format and operation encodings of RV32I
//////////////////////////////

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    // funct7 values of the base and alternate ALU encodings
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // Major opcodes
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        R_FMT,
        I_FMT,
        S_FMT,
        B_FMT,
        U_FMT,
        J_FMT
    } format_e;

    // Operation handed to the execute stage
    typedef enum logic [5:0] {
        NOP, LUI, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ECALL, EBREAK,
        INVALID
    } op_e;

endpackage

// ==== hdl/op_decoder.sv ====
//////////////////////////////
// Operation decoder
// Maps opcode, funct3, funct7 and the system field
// to an operation and an instruction format
//////////////////////////////

`timescale 1ns/100ps

module op_decoder (
    input  decode_pkg::word_t   instruction_i,
    output decode_pkg::op_e     operation_o,
    output decode_pkg::format_e format_o
);

    import decode_pkg::*;

    opcode_e                    opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [FUNCT7_MSB-RD_LSB:0] system_field;
    op_e                        op_branch;
    op_e                        op_load;
    op_e                        op_store;
    op_e                        op_imm;
    op_e                        op_reg;

    assign opcode       = opcode_e'(instruction_i[OPCODE_MSB:OPCODE_LSB]);
    assign funct3       = instruction_i[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7       = instruction_i[FUNCT7_MSB:FUNCT7_LSB];
    assign system_field = instruction_i[FUNCT7_MSB:RD_LSB];

    //////////////////////////////
    // Per-class decode
    //////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates keep the funct7 rule, the rest ignore it
    always_comb begin
        unique case (funct3)
            3'b000:  op_imm = ADD;
            3'b001:  op_imm = (funct7 == FUNCT7_BASE) ? SLL : INVALID;
            3'b010:  op_imm = SLT;
            3'b011:  op_imm = SLTU;
            3'b100:  op_imm = XOR;
            3'b101:  op_imm = (funct7 == FUNCT7_BASE) ? SRL :
                              (funct7 == FUNCT7_ALT)  ? SRA : INVALID;
            3'b110:  op_imm = OR;
            default: op_imm = AND;
        endcase
    end

    always_comb begin
        unique case ({funct7, funct3})
            {FUNCT7_BASE, 3'b000}: op_reg = ADD;
            {FUNCT7_ALT,  3'b000}: op_reg = SUB;
            {FUNCT7_BASE, 3'b001}: op_reg = SLL;
            {FUNCT7_BASE, 3'b010}: op_reg = SLT;
            {FUNCT7_BASE, 3'b011}: op_reg = SLTU;
            {FUNCT7_BASE, 3'b100}: op_reg = XOR;
            {FUNCT7_BASE, 3'b101}: op_reg = SRL;
            {FUNCT7_ALT,  3'b101}: op_reg = SRA;
            {FUNCT7_BASE, 3'b110}: op_reg = OR;
            {FUNCT7_BASE, 3'b111}: op_reg = AND;
            default:               op_reg = INVALID;
        endcase
    end

    //////////////////////////////
    // Operation and format select
    //////////////////////////////

    // Opcodes not listed here are taken as R format
    always_comb begin
        unique case (opcode)
            OPC_LUI, OPC_AUIPC:             format_o = U_FMT;
            OPC_JAL:                        format_o = J_FMT;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: format_o = I_FMT;
            OPC_BRANCH:                     format_o = B_FMT;
            OPC_STORE:                      format_o = S_FMT;
            default:                        format_o = R_FMT;
        endcase
    end

    always_comb begin
        operation_o = INVALID;
        unique case (opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = op_branch;
            OPC_LOAD:     operation_o = op_load;
            OPC_STORE:    operation_o = op_store;
            OPC_OP_IMM:   operation_o = op_imm;
            OPC_OP:       operation_o = op_reg;
            // FENCE has no effect in an in-order core
            OPC_MISC_MEM: operation_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM: begin
                if (system_field == '0) begin
                    operation_o = ECALL;
                end else if (system_field == {12'h001, 13'h0000}) begin
                    operation_o = EBREAK;
                end
            end
            default:      operation_o = INVALID;
        endcase
    end

endmodule

// ==== hdl/imm_gen.sv ====
//////////////////////////////
// Immediate generator
// Gathers the scattered immediate bits of each format
// into a sign-extended 32-bit word
//////////////////////////////

`timescale 1ns/100ps

module imm_gen (
    input  decode_pkg::word_t   instruction_i,
    input  decode_pkg::format_e format_i,
    output decode_pkg::word_t   immediate_o
);

    import decode_pkg::*;

    logic  sign;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign sign  = instruction_i[FUNCT7_MSB];

    assign imm_i = {{20{sign}}, instruction_i[FUNCT7_MSB:RS2_LSB]};
    assign imm_s = {{20{sign}}, instruction_i[FUNCT7_MSB:FUNCT7_LSB], instruction_i[RD_MSB:RD_LSB]};
    // Branch offsets are in halfwords, bit 0 is implied
    assign imm_b = {{20{sign}}, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[FUNCT7_MSB:FUNCT3_LSB], 12'b0};
    assign imm_j = {{12{sign}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        unique case (format_i)
            I_FMT:   immediate_o = imm_i;
            S_FMT:   immediate_o = imm_s;
            B_FMT:   immediate_o = imm_b;
            U_FMT:   immediate_o = imm_u;
            J_FMT:   immediate_o = imm_j;
            default: immediate_o = '0;
        endcase
    end

endmodule

// ==== hdl/hazard_unit.sv ====
//////////////////////////////
// Hazard unit
// Replay register, register lock and store lock.
// Flags a read-after-write or store-then-memory hazard
//////////////////////////////

`timescale 1ns/100ps

module hazard_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  decode_pkg::word_t     instruction_i,
    input  decode_pkg::format_e   format_i,
    output decode_pkg::word_t     cur_instr_o,
    output logic                  hazard_o,
    output decode_pkg::reg_addr_t rd_o
);

    import decode_pkg::*;

    word_t     last_instr;
    logic      last_stall;
    logic      last_hazard;
    reg_addr_t locked_reg;
    logic      locked_mem;
    opcode_e   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_rs1;
    logic      use_rs2;
    logic      use_mem;

    //////////////////////////////
    // Replay
    //////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= cur_instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_stall  <= 1'b0;
            last_hazard <= 1'b0;
        end else begin
            last_stall  <= stall_i;
            last_hazard <= hazard_o;
        end
    end

    // Held word is decoded again after a stall or a bubble
    assign cur_instr_o = (last_stall || last_hazard) ? last_instr : instruction_i;

    assign opcode = opcode_e'(cur_instr_o[OPCODE_MSB:OPCODE_LSB]);
    assign rs1    = cur_instr_o[RS1_MSB:RS1_LSB];
    assign rs2    = cur_instr_o[RS2_MSB:RS2_LSB];

    //////////////////////////////
    // Locks
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
            rd_o       <= '0;
        end else if (!stall_i) begin
            locked_reg <= hazard_o ? '0 : cur_instr_o[RD_MSB:RD_LSB];
            locked_mem <= !hazard_o && (opcode == OPC_STORE);
            rd_o       <= locked_reg;
        end
    end

    // U and J formats read no register
    assign use_rs1 = (format_i == R_FMT) || (format_i == B_FMT) ||
                     (format_i == S_FMT) || (format_i == I_FMT);
    assign use_rs2 = (format_i == R_FMT) || (format_i == B_FMT) || (format_i == S_FMT);
    assign use_mem = (opcode == OPC_LOAD) || (opcode == OPC_STORE);

    assign hazard_o = !stall_i &&
                      ((use_rs1 && rs1 != '0 && rs1 == locked_reg) ||
                       (use_rs2 && rs2 != '0 && rs2 == locked_reg) ||
                       (use_mem && locked_mem));

endmodule

// ==== hdl/operand_stage.sv ====
//////////////////////////////
// Operand stage
// Routes register data, PC and immediate onto the three
// operands and registers them with the exception flags
//////////////////////////////

`timescale 1ns/100ps

module operand_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall_i,
    input  logic                hazard_i,
    input  decode_pkg::word_t   instruction_i,
    input  decode_pkg::word_t   pc_i,
    input  decode_pkg::word_t   immediate_i,
    input  decode_pkg::word_t   rs1_data_i,
    input  decode_pkg::word_t   rs2_data_i,
    input  decode_pkg::op_e     operation_i,
    input  decode_pkg::format_e format_i,
    output decode_pkg::word_t   first_operand_o,
    output decode_pkg::word_t   second_operand_o,
    output decode_pkg::word_t   third_operand_o,
    output decode_pkg::word_t   pc_o,
    output decode_pkg::op_e     operation_o,
    output logic                illegal_inst_o,
    output logic                misaligned_fetch_o
);

    import decode_pkg::*;

    word_t first_operand;
    word_t second_operand;
    word_t third_operand;
    logic  illegal_inst;
    logic  misaligned_fetch;

    always_comb begin
        unique case (format_i)
            U_FMT, J_FMT: begin
                first_operand  = pc_i;
                second_operand = immediate_i;
                third_operand  = immediate_i;
            end
            R_FMT, B_FMT: begin
                first_operand  = rs1_data_i;
                second_operand = rs2_data_i;
                third_operand  = immediate_i;
            end
            // Store data rides on the third operand
            S_FMT: begin
                first_operand  = rs1_data_i;
                second_operand = immediate_i;
                third_operand  = rs2_data_i;
            end
            default: begin
                first_operand  = rs1_data_i;
                second_operand = immediate_i;
                third_operand  = immediate_i;
            end
        endcase
    end

    // Only 32-bit encodings are legal, low opcode bits must be 11
    assign illegal_inst     = (operation_i == INVALID) ||
                              (instruction_i[OPCODE_LSB+1:OPCODE_LSB] != 2'b11);
    assign misaligned_fetch = |pc_i[1:0];

    //////////////////////////////
    // Stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || hazard_i) begin
            first_operand_o    <= '0;
            second_operand_o   <= '0;
            third_operand_o    <= '0;
            pc_o               <= '0;
            operation_o        <= NOP;
            illegal_inst_o     <= 1'b0;
            misaligned_fetch_o <= 1'b0;
        end else if (!stall_i) begin
            first_operand_o    <= first_operand;
            second_operand_o   <= second_operand;
            third_operand_o    <= third_operand;
            pc_o               <= pc_i;
            operation_o        <= operation_i;
            illegal_inst_o     <= illegal_inst;
            misaligned_fetch_o <= misaligned_fetch;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
//////////////////////////////
// Decode stage
// Instruction decode of an in-order RV32I core.
// Replay and hazard logic, operation and immediate
// decode, operand routing into the stage register
//////////////////////////////

`timescale 1ns/100ps

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  decode_pkg::word_t     instruction_i,
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::word_t     rs1_data_i,
    input  decode_pkg::word_t     rs2_data_i,
    output decode_pkg::reg_addr_t rs1_addr_o,
    output decode_pkg::reg_addr_t rs2_addr_o,
    output decode_pkg::reg_addr_t rd_o,
    output decode_pkg::word_t     first_operand_o,
    output decode_pkg::word_t     second_operand_o,
    output decode_pkg::word_t     third_operand_o,
    output decode_pkg::word_t     pc_o,
    output decode_pkg::op_e       operation_o,
    output logic                  hazard_o,
    output logic                  illegal_inst_o,
    output logic                  misaligned_fetch_o
);

    import decode_pkg::*;

    word_t   cur_instr;
    op_e     operation;
    format_e format;
    word_t   immediate;

    // Register file is read in the decode cycle
    assign rs1_addr_o = cur_instr[RS1_MSB:RS1_LSB];
    assign rs2_addr_o = cur_instr[RS2_MSB:RS2_LSB];

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .format_i      (format),
        .cur_instr_o   (cur_instr),
        .hazard_o      (hazard_o),
        .rd_o          (rd_o)
    );

    op_decoder u_op_decoder (
        .instruction_i (cur_instr),
        .operation_o   (operation),
        .format_o      (format)
    );

    imm_gen u_imm_gen (
        .instruction_i (cur_instr),
        .format_i      (format),
        .immediate_o   (immediate)
    );

    operand_stage u_operand_stage (
        .clk                (clk),
        .reset              (reset),
        .stall_i            (stall_i),
        .hazard_i           (hazard_o),
        .instruction_i      (cur_instr),
        .pc_i               (pc_i),
        .immediate_i        (immediate),
        .rs1_data_i         (rs1_data_i),
        .rs2_data_i         (rs2_data_i),
        .operation_i        (operation),
        .format_i           (format),
        .first_operand_o    (first_operand_o),
        .second_operand_o   (second_operand_o),
        .third_operand_o    (third_operand_o),
        .pc_o               (pc_o),
        .operation_o        (operation_o),
        .illegal_inst_o     (illegal_inst_o),
        .misaligned_fetch_o (misaligned_fetch_o)
    );

endmodule

// ==== verification/decode_properties.sv ====
//////////////////////////////
// Decode stage properties
// Reset values, bubble after hazard, single-cycle hazard
//////////////////////////////

`timescale 1ns/100ps

module decode_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  stall_i,
    input logic                  hazard_o,
    input decode_pkg::op_e       operation_o,
    input logic                  illegal_inst_o,
    input logic                  misaligned_fetch_o,
    input decode_pkg::reg_addr_t rd_o
);

    import decode_pkg::*;

    int fail_count = 0;

    reset_values: assert property (@(posedge clk)
        reset |=> (operation_o == NOP && !illegal_inst_o && !misaligned_fetch_o && rd_o == '0))
        else begin fail_count++; $error("Stage outputs not cleared by reset"); end

    bubble_after_hazard: assert property (@(posedge clk) disable iff (reset)
        hazard_o |=> operation_o == NOP)
        else begin fail_count++; $error("No NOP bubble after hazard"); end

    single_hazard: assert property (@(posedge clk) disable iff (reset)
        (hazard_o && !stall_i) |=> !(hazard_o && !stall_i))
        else begin fail_count++; $error("Hazard held for two cycles"); end

endmodule

// ==== verification/decode_checker.sv ====
//////////////////////////////
// Decode checker
// Compares hazard_o and the register file addresses in
// the row cycle and the stage register one edge later
//////////////////////////////

`timescale 1ns/100ps

module decode_checker (
    input  logic                  clk,
    input  logic                  row_valid_i,
    input  logic [95:0]           name_i,
    input  logic                  exp_hazard_i,
    input  decode_pkg::reg_addr_t exp_rs1_addr_i,
    input  decode_pkg::reg_addr_t exp_rs2_addr_i,
    input  decode_pkg::op_e       exp_op_i,
    input  decode_pkg::word_t     exp_first_i,
    input  decode_pkg::word_t     exp_second_i,
    input  decode_pkg::word_t     exp_third_i,
    input  decode_pkg::word_t     exp_pc_i,
    input  logic                  exp_illegal_i,
    input  logic                  exp_misaligned_i,
    input  decode_pkg::reg_addr_t exp_rd_i,
    input  logic                  hazard_i,
    input  decode_pkg::reg_addr_t rs1_addr_i,
    input  decode_pkg::reg_addr_t rs2_addr_i,
    input  decode_pkg::op_e       operation_i,
    input  decode_pkg::word_t     first_operand_i,
    input  decode_pkg::word_t     second_operand_i,
    input  decode_pkg::word_t     third_operand_i,
    input  decode_pkg::word_t     pc_i,
    input  logic                  illegal_inst_i,
    input  logic                  misaligned_fetch_i,
    input  decode_pkg::reg_addr_t rd_i,
    output int                    tests_done_o,
    output int                    errors_o
);

    import decode_pkg::*;

    logic        pend_valid;
    logic [95:0] pend_name;
    logic [31:0] pend_exp [8];
    int          test_errors;

    initial begin
        pend_valid   = 1'b0;
        tests_done_o = 0;
        errors_o     = 0;
        test_errors  = 0;
    end

    task automatic compare_value(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %0s %0s: expected %h actual %h", pend_name, field, exp, act);
            test_errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (pend_valid) begin
            compare_value("operation_o", pend_exp[0], 32'(operation_i));
            compare_value("first_operand_o", pend_exp[1], first_operand_i);
            compare_value("second_operand_o", pend_exp[2], second_operand_i);
            compare_value("third_operand_o", pend_exp[3], third_operand_i);
            compare_value("pc_o", pend_exp[4], pc_i);
            compare_value("illegal_inst_o", pend_exp[5], 32'(illegal_inst_i));
            compare_value("misaligned_fetch_o", pend_exp[6], 32'(misaligned_fetch_i));
            compare_value("rd_o", pend_exp[7], 32'(rd_i));
            $display("Test %0d %0s: %0s", tests_done_o, pend_name,
                     (test_errors == 0) ? "ok" : "failed");
            errors_o += test_errors;
            tests_done_o++;
            test_errors = 0;
        end
        pend_valid = row_valid_i;
        if (row_valid_i) begin
            pend_name = name_i;
            compare_value("hazard_o", 32'(exp_hazard_i), 32'(hazard_i));
            // Register file is addressed in the decode cycle
            compare_value("rs1_addr_o", 32'(exp_rs1_addr_i), 32'(rs1_addr_i));
            compare_value("rs2_addr_o", 32'(exp_rs2_addr_i), 32'(rs2_addr_i));
            pend_exp[0] = 32'(exp_op_i);
            pend_exp[1] = exp_first_i;
            pend_exp[2] = exp_second_i;
            pend_exp[3] = exp_third_i;
            pend_exp[4] = exp_pc_i;
            pend_exp[5] = 32'(exp_illegal_i);
            pend_exp[6] = 32'(exp_misaligned_i);
            pend_exp[7] = 32'(exp_rd_i);
        end
    end

endmodule

// ==== verification/decode_tb.sv ====
//////////////////////////////
// Decode stage testbench
// Clock, reset, stimulus table applied in a loop,
// expected values built from the ISA and stage rules
//////////////////////////////

`timescale 1ns/100ps

module decode_tb;

    import decode_pkg::*;

    localparam int NUM_ROWS    = 31;
    localparam int CYCLE_LIMIT = 2 * NUM_ROWS + 20;

    logic clk, reset, stall, row_valid, hazard, illegal_inst, misaligned_fetch;
    word_t instruction, pc, rs1_data, rs2_data, first_operand, second_operand;
    word_t third_operand, pc_out;
    reg_addr_t rs1_addr, rs2_addr, rd;
    op_e operation;
    int row_count, cycle_count, tests_done, check_errors;

    // Stimulus columns
    logic [95:0] t_name [NUM_ROWS];
    word_t t_instr [NUM_ROWS], t_pc [NUM_ROWS], t_rs1 [NUM_ROWS], t_rs2 [NUM_ROWS];
    word_t t_imm [NUM_ROWS];
    logic t_stall [NUM_ROWS], t_hazard [NUM_ROWS];
    op_e t_op [NUM_ROWS];
    format_e t_fmt [NUM_ROWS];
    // Register file addresses expected in the row cycle
    reg_addr_t e_rs1 [NUM_ROWS], e_rs2 [NUM_ROWS];
    // Expected stage register contents after each row
    word_t e_first [NUM_ROWS], e_second [NUM_ROWS], e_third [NUM_ROWS], e_pc [NUM_ROWS];
    op_e e_op [NUM_ROWS];
    logic e_illegal [NUM_ROWS], e_misaligned [NUM_ROWS];
    reg_addr_t e_rd [NUM_ROWS];
    int cur;

    decode_stage DUT (
        .clk (clk), .reset (reset), .stall_i (stall), .instruction_i (instruction),
        .pc_i (pc), .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr), .rd_o (rd),
        .first_operand_o (first_operand), .second_operand_o (second_operand),
        .third_operand_o (third_operand), .pc_o (pc_out), .operation_o (operation),
        .hazard_o (hazard), .illegal_inst_o (illegal_inst),
        .misaligned_fetch_o (misaligned_fetch)
    );

    decode_checker u_checker (
        .clk (clk), .row_valid_i (row_valid), .name_i (t_name[cur]),
        .exp_hazard_i (t_hazard[cur]), .exp_rs1_addr_i (e_rs1[cur]),
        .exp_rs2_addr_i (e_rs2[cur]), .exp_op_i (e_op[cur]),
        .exp_first_i (e_first[cur]), .exp_second_i (e_second[cur]),
        .exp_third_i (e_third[cur]), .exp_pc_i (e_pc[cur]),
        .exp_illegal_i (e_illegal[cur]), .exp_misaligned_i (e_misaligned[cur]),
        .exp_rd_i (e_rd[cur]), .hazard_i (hazard), .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr), .operation_i (operation),
        .first_operand_i (first_operand), .second_operand_i (second_operand),
        .third_operand_i (third_operand), .pc_i (pc_out), .illegal_inst_i (illegal_inst),
        .misaligned_fetch_i (misaligned_fetch), .rd_i (rd),
        .tests_done_o (tests_done), .errors_o (check_errors)
    );

    bind decode_stage decode_properties u_properties (
        .clk (clk), .reset (reset), .stall_i (stall_i), .hazard_o (hazard_o),
        .operation_o (operation_o), .illegal_inst_o (illegal_inst_o),
        .misaligned_fetch_o (misaligned_fetch_o), .rd_o (rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd_f, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd_f, opc};
    endfunction

    function automatic word_t enc_i(word_t imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd_f, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd_f, opc};
    endfunction

    function automatic word_t enc_s(word_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(word_t imm, reg_addr_t rs2, reg_addr_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(word_t imm, reg_addr_t rd_f);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd_f, 7'h6f};
    endfunction

    task automatic add_row(input logic [95:0] name, input word_t instr, input word_t addr,
                           input logic stl, input logic haz, input op_e op,
                           input format_e fmt, input word_t imm);
        t_name[row_count]   = name;
        t_instr[row_count]  = instr;
        t_pc[row_count]     = addr;
        t_rs1[row_count]    = $urandom;
        t_rs2[row_count]    = $urandom;
        t_stall[row_count]  = stl;
        t_hazard[row_count] = haz;
        t_op[row_count]     = op;
        t_fmt[row_count]    = fmt;
        t_imm[row_count]    = imm;
        row_count++;
    endtask

    // Walk the table through the stage register, lock and rd rules
    task automatic build_expectations();
        word_t     f;
        word_t     s;
        word_t     t;
        word_t     p;
        op_e       o;
        logic      il;
        logic      mis;
        reg_addr_t lock;
        reg_addr_t rd_q;
        f    = '0;
        s    = '0;
        t    = '0;
        p    = '0;
        o    = NOP;
        il   = 1'b0;
        mis  = 1'b0;
        lock = '0;
        rd_q = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            // rs1 and rs2 fields of the RV32I encoding
            e_rs1[i] = t_instr[i][19:15];
            e_rs2[i] = t_instr[i][24:20];
            if (!t_stall[i]) begin
                if (t_hazard[i]) begin
                    f   = '0;
                    s   = '0;
                    t   = '0;
                    p   = '0;
                    o   = NOP;
                    il  = 1'b0;
                    mis = 1'b0;
                end else begin
                    p   = t_pc[i];
                    o   = t_op[i];
                    il  = (t_op[i] == INVALID);
                    mis = |t_pc[i][1:0];
                    case (t_fmt[i])
                        U_FMT, J_FMT: begin
                            f = t_pc[i];
                            s = t_imm[i];
                            t = t_imm[i];
                        end
                        R_FMT, B_FMT: begin
                            f = t_rs1[i];
                            s = t_rs2[i];
                            t = t_imm[i];
                        end
                        S_FMT: begin
                            f = t_rs1[i];
                            s = t_imm[i];
                            t = t_rs2[i];
                        end
                        default: begin
                            f = t_rs1[i];
                            s = t_imm[i];
                            t = t_imm[i];
                        end
                    endcase
                end
                rd_q = lock;
                lock = t_hazard[i] ? 5'd0 : t_instr[i][11:7];
            end
            e_first[i]      = f;
            e_second[i]     = s;
            e_third[i]      = t;
            e_pc[i]         = p;
            e_op[i]         = o;
            e_illegal[i]    = il;
            e_misaligned[i] = mis;
            e_rd[i]         = rd_q;
        end
    endtask

    task automatic fill_table();
        word_t w;
        w = {20'h12345, 5'd10, 7'h37};
        add_row("reset_hold", w, 32'h100, 1, 0, LUI, U_FMT, 32'h12345000);
        add_row("lui", w, 32'h100, 0, 0, LUI, U_FMT, 32'h12345000);
        add_row("auipc", {20'hfffff, 5'd11, 7'h17}, 32'h104, 0, 0, ADD, U_FMT, 32'hfffff000);
        add_row("jal", enc_j(32'hffffff00, 12), 32'h108, 0, 0, JAL, J_FMT, 32'hffffff00);
        add_row("jalr", enc_i(32'h10, 1, 0, 13, 7'h67), 32'h10c, 0, 0, JALR, I_FMT, 32'h10);
        add_row("addi", enc_i(32'hfffff800, 2, 0, 14, 7'h13), 32'h110, 0, 0, ADD, I_FMT,
                32'hfffff800);
        add_row("srai", enc_i(32'h403, 3, 5, 15, 7'h13), 32'h114, 0, 0, SRA, I_FMT, 32'h403);
        add_row("sub", enc_r(7'h20, 2, 1, 0, 16, 7'h33), 32'h118, 0, 0, SUB, R_FMT, 0);
        add_row("and", enc_r(7'h00, 3, 2, 7, 17, 7'h33), 32'h11c, 0, 0, AND, R_FMT, 0);
        add_row("bne", enc_b(32'hfffffff0, 2, 1, 1), 32'h120, 0, 0, BNE, B_FMT, 32'hfffffff0);
        add_row("lw", enc_i(32'h8, 1, 2, 18, 7'h03), 32'h124, 0, 0, LW, I_FMT, 32'h8);
        add_row("sw", enc_s(32'h14, 2, 3, 2), 32'h128, 0, 0, SW, S_FMT, 32'h14);
        add_row("st_then_alu", enc_r(7'h00, 2, 1, 0, 21, 7'h33), 32'h12c, 0, 0, ADD, R_FMT, 0);
        add_row("sb", enc_s(32'hfffffffc, 3, 1, 0), 32'h130, 0, 0, SB, S_FMT, 32'hfffffffc);
        w = enc_i(32'h4, 2, 4, 22, 7'h03);
        add_row("mem_hazard", w, 32'h134, 0, 1, LBU, I_FMT, 32'h4);
        add_row("lbu_replay", w, 32'h134, 0, 0, LBU, I_FMT, 32'h4);
        add_row("write_x5", enc_i(32'h1, 1, 0, 5, 7'h13), 32'h138, 0, 0, ADD, I_FMT, 32'h1);
        w = enc_r(7'h00, 5, 2, 6, 23, 7'h33);
        add_row("raw_x5", w, 32'h13c, 0, 1, OR, R_FMT, 0);
        add_row("or_replay", w, 32'h13c, 0, 0, OR, R_FMT, 0);
        add_row("write_x0", enc_i(32'h7, 1, 0, 0, 7'h13), 32'h140, 0, 0, ADD, I_FMT, 32'h7);
        add_row("read_x0", enc_r(7'h00, 0, 0, 4, 24, 7'h33), 32'h144, 0, 0, XOR, R_FMT, 0);
        w = enc_r(7'h00, 3, 1, 2, 25, 7'h33);
        add_row("stall_1", w, 32'h148, 1, 0, SLT, R_FMT, 0);
        add_row("stall_2", w, 32'h148, 1, 0, SLT, R_FMT, 0);
        add_row("slt_release", w, 32'h148, 0, 0, SLT, R_FMT, 0);
        add_row("ecall", 32'h00000073, 32'h14c, 0, 0, ECALL, R_FMT, 0);
        add_row("ebreak", 32'h00100073, 32'h150, 0, 0, EBREAK, R_FMT, 0);
        add_row("fence", 32'h0ff0000f, 32'h154, 0, 0, NOP, R_FMT, 0);
        add_row("csrrw", 32'h30529073, 32'h158, 0, 0, INVALID, R_FMT, 0);
        add_row("bad_opcode", 32'h0000007f, 32'h15c, 0, 0, INVALID, R_FMT, 0);
        add_row("misaligned", enc_i(32'h10, 1, 0, 26, 7'h13), 32'h202, 0, 0, ADD, I_FMT, 32'h10);
        add_row("last_addi", 32'h00000013, 32'h300, 0, 0, ADD, I_FMT, 0);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run stopped: limit of %0d cycles reached before all tests finished",
                     CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        void'($urandom(53486));
        reset       = 1'b1;
        stall       = 1'b0;
        instruction = 32'h00000013;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        row_valid   = 1'b0;
        row_count   = 0;
        cycle_count = 0;
        cur         = 0;
        fill_table();
        build_expectations();
        repeat (2) @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            reset       <= 1'b0;
            row_valid   <= 1'b1;
            cur         <= i;
            stall       <= t_stall[i];
            instruction <= t_instr[i];
            pc          <= t_pc[i];
            rs1_data    <= t_rs1[i];
            rs2_data    <= t_rs2[i];
        end
        @(posedge clk);
        row_valid <= 1'b0;
        stall     <= 1'b1;
        wait (tests_done == NUM_ROWS);
        $display("Tests run: %0d, check errors: %0d, assertion failures: %0d",
                 tests_done, check_errors, DUT.u_properties.fail_count);
        if (check_errors == 0 && DUT.u_properties.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/decode_pkg.sv
hdl/op_decoder.sv
hdl/imm_gen.sv
hdl/hazard_unit.sv
hdl/operand_stage.sv
hdl/decode_stage.sv
verification/decode_properties.sv
verification/decode_checker.sv
verification/decode_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hdl/decode_pkg.sv
  - hdl/op_decoder.sv
  - hdl/imm_gen.sv
  - hdl/hazard_unit.sv
  - hdl/operand_stage.sv
  - hdl/decode_stage.sv
  - target: test
    files:
      - verification/decode_properties.sv
      - verification/decode_checker.sv
      - verification/decode_tb.sv
